/* verilog/lc_pkg.sv */
`default_nettype none

package lc_pkg;

	// Message port
	localparam int FID_WIDTH = 4;
	localparam int DATA_WIDTH = 32;

	// Always-on storage
	localparam int RF_DATA_WIDTH = 24;
	localparam int RF_DEPTH = 16;
	localparam int RF_ADDR_WIDTH = $clog2(RF_DEPTH);
	localparam int MEM_DATA_WIDTH = 16;
	localparam int MEM_DEPTH = 256;
	localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);

	// Interrupt lines
	localparam int INT_DEPTH = 4;
	localparam int INT_IDX_WIDTH = $clog2(INT_DEPTH);

	// Function ids
	localparam logic [FID_WIDTH-1:0] FID_REG_WR = 4'd0;
	localparam logic [FID_WIDTH-1:0] FID_REG_RD = 4'd1;
	localparam logic [FID_WIDTH-1:0] FID_MEM_WR = 4'd2;
	localparam logic [FID_WIDTH-1:0] FID_MEM_RD = 4'd3;
	localparam logic [FID_WIDTH-1:0] FID_SLEEP = 4'd4;
	localparam logic [FID_WIDTH-1:0] FID_INT = 4'd13;
	localparam logic [FID_WIDTH-1:0] FID_REPLY = 4'd14;

	// One message word per interrupt line, entry 0 in the low bits
	localparam logic [INT_DEPTH-1:0][DATA_WIDTH-1:0] INT_PAYLOAD = {
		32'hC0DE_0003,
		32'hC0DE_0002,
		32'hC0DE_0001,
		32'hC0DE_0000
	};

	// Power sequencer states
	localparam int PWR_STATE_WIDTH = 3;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_ASLEEP = 3'd0;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_ON = 3'd1;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_CLK = 3'd2;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_UNISO = 3'd3;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_AWAKE = 3'd4;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_ISO = 3'd5;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_RST = 3'd6;
	localparam logic [PWR_STATE_WIDTH-1:0] PWR_GATE = 3'd7;

	// Layer controller states
	localparam int LC_STATE_WIDTH = 3;
	localparam logic [LC_STATE_WIDTH-1:0] LC_IDLE = 3'd0;
	localparam logic [LC_STATE_WIDTH-1:0] LC_MEM_WAIT = 3'd1;
	localparam logic [LC_STATE_WIDTH-1:0] LC_REPLY = 3'd2;
	localparam logic [LC_STATE_WIDTH-1:0] LC_INT_TX = 3'd3;
	localparam logic [LC_STATE_WIDTH-1:0] LC_DONE = 3'd4;
	localparam logic [LC_STATE_WIDTH-1:0] LC_SLEEP = 3'd5;
	localparam logic [LC_STATE_WIDTH-1:0] LC_HALT = 3'd6;

	// Received word, read either as a register or as a memory access
	typedef struct packed {
		logic [DATA_WIDTH-RF_DATA_WIDTH-1:0] reg_addr;
		logic [RF_DATA_WIDTH-1:0] reg_data;
	} rf_view_t;

	typedef struct packed {
		logic [MEM_ADDR_WIDTH-1:0] mem_addr;
		logic [DATA_WIDTH-MEM_ADDR_WIDTH-MEM_DATA_WIDTH-1:0] reserved;
		logic [MEM_DATA_WIDTH-1:0] mem_data;
	} mem_view_t;

	typedef union packed {
		rf_view_t rf;
		mem_view_t mem;
	} msg_word_t;

endpackage

`default_nettype wire

/* verilog/power_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module power_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic rx_req,
	input  logic [lc_pkg::INT_DEPTH-1:0] int_vector,
	input  logic lc_sleep,
	output logic lc_power,
	output logic lc_clk_en,
	output logic lc_rst_n,
	output logic lc_iso,
	// From the controller domain
	input  logic rx_ack_lc,
	input  logic tx_req_lc,
	input  logic [lc_pkg::FID_WIDTH-1:0] tx_fid_lc,
	input  logic [lc_pkg::DATA_WIDTH-1:0] tx_data_lc,
	input  logic [lc_pkg::INT_DEPTH-1:0] clr_int_lc,
	input  logic [lc_pkg::RF_DEPTH-1:0] rf_load_lc,
	input  logic [lc_pkg::RF_DATA_WIDTH-1:0] rf_wr_data_lc,
	input  logic mem_req_lc,
	input  logic mem_write_lc,
	input  logic [lc_pkg::MEM_ADDR_WIDTH-1:0] mem_addr_lc,
	input  logic [lc_pkg::MEM_DATA_WIDTH-1:0] mem_wr_data_lc,
	// Clamped copies
	output logic rx_ack,
	output logic tx_req,
	output logic [lc_pkg::FID_WIDTH-1:0] tx_fid,
	output logic [lc_pkg::DATA_WIDTH-1:0] tx_data,
	output logic [lc_pkg::INT_DEPTH-1:0] clr_int,
	output logic [lc_pkg::RF_DEPTH-1:0] rf_load,
	output logic [lc_pkg::RF_DATA_WIDTH-1:0] rf_wr_data,
	output logic mem_req,
	output logic mem_write,
	output logic [lc_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
	output logic [lc_pkg::MEM_DATA_WIDTH-1:0] mem_wr_data
);

	import lc_pkg::*;

	logic [PWR_STATE_WIDTH-1:0] state;
	logic [PWR_STATE_WIDTH-1:0] next_state;
	logic wake;

	assign wake = rx_req || (|int_vector);

	// One step per cycle in both directions
	always_comb
	begin
		next_state = state;
		case (state)
			PWR_ASLEEP: if (wake) next_state = PWR_ON;
			PWR_ON: next_state = PWR_CLK;
			PWR_CLK: next_state = PWR_UNISO;
			PWR_UNISO: next_state = PWR_AWAKE;
			PWR_AWAKE: if (lc_sleep) next_state = PWR_ISO;
			PWR_ISO: next_state = PWR_RST;
			PWR_RST: next_state = PWR_GATE;
			default: next_state = PWR_ASLEEP;
		endcase
	end

	// Controls are registered from the next state so they never glitch
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= PWR_ASLEEP;
			lc_power <= 1'b0;
			lc_clk_en <= 1'b0;
			lc_iso <= 1'b1;
			lc_rst_n <= 1'b0;
		end
		else
		begin
			state <= next_state;
			lc_power <= (next_state != PWR_ASLEEP);
			lc_clk_en <= next_state inside {PWR_CLK, PWR_UNISO, PWR_AWAKE, PWR_ISO, PWR_RST};
			lc_iso <= !(next_state inside {PWR_UNISO, PWR_AWAKE});
			lc_rst_n <= next_state inside {PWR_AWAKE, PWR_ISO};
		end
	end

	// Isolation clamp to zero
	assign rx_ack = rx_ack_lc & ~lc_iso;
	assign tx_req = tx_req_lc & ~lc_iso;
	assign tx_fid = tx_fid_lc & {FID_WIDTH{~lc_iso}};
	assign tx_data = tx_data_lc & {DATA_WIDTH{~lc_iso}};
	assign clr_int = clr_int_lc & {INT_DEPTH{~lc_iso}};
	assign rf_load = rf_load_lc & {RF_DEPTH{~lc_iso}};
	assign rf_wr_data = rf_wr_data_lc & {RF_DATA_WIDTH{~lc_iso}};
	assign mem_req = mem_req_lc & ~lc_iso;
	assign mem_write = mem_write_lc & ~lc_iso;
	assign mem_addr = mem_addr_lc & {MEM_ADDR_WIDTH{~lc_iso}};
	assign mem_wr_data = mem_wr_data_lc & {MEM_DATA_WIDTH{~lc_iso}};

	// Domain must never drive outputs while unpowered
	iso_when_off: assert property (@(posedge clk) disable iff (!arst_n) !lc_power |-> lc_iso)
		else $error("power_ctrl: isolation released while domain is off");

endmodule

`default_nettype wire

/* verilog/layer_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module layer_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic lc_clk_en,
	input  logic lc_rst_n,
	input  logic rx_req,
	input  logic [lc_pkg::FID_WIDTH-1:0] rx_fid,
	input  logic [lc_pkg::DATA_WIDTH-1:0] rx_data,
	output logic rx_ack,
	output logic tx_req,
	output logic [lc_pkg::FID_WIDTH-1:0] tx_fid,
	output logic [lc_pkg::DATA_WIDTH-1:0] tx_data,
	input  logic tx_ack,
	input  logic [lc_pkg::INT_DEPTH-1:0] int_vector,
	output logic [lc_pkg::INT_DEPTH-1:0] clr_int,
	output logic lc_sleep,
	output logic [lc_pkg::RF_DATA_WIDTH-1:0] rf_wr_data,
	output logic [lc_pkg::RF_DEPTH-1:0] rf_load,
	input  logic [lc_pkg::RF_DEPTH*lc_pkg::RF_DATA_WIDTH-1:0] rf_rd_data,
	output logic mem_req,
	output logic mem_write,
	output logic [lc_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
	output logic [lc_pkg::MEM_DATA_WIDTH-1:0] mem_wr_data,
	input  logic mem_ack,
	input  logic [lc_pkg::MEM_DATA_WIDTH-1:0] mem_rd_data
);

	import lc_pkg::*;

	logic ctrl_rst_n;
	logic [LC_STATE_WIDTH-1:0] state;
	msg_word_t rx_word;
	msg_word_t rf_reply;
	msg_word_t mem_reply;
	logic reg_valid;
	logic [RF_ADDR_WIDTH-1:0] reg_idx;
	logic [RF_DATA_WIDTH-1:0] rf_value;
	logic int_any;
	logic [INT_IDX_WIDTH-1:0] int_sel;
	logic [INT_IDX_WIDTH-1:0] int_idx;

	// Held in reset by the sequencer as well as by the system reset
	assign ctrl_rst_n = arst_n & lc_rst_n;

	assign rx_word = rx_data;
	assign reg_valid = (rx_word.rf.reg_addr < RF_DEPTH);
	assign reg_idx = rx_word.rf.reg_addr[RF_ADDR_WIDTH-1:0];
	assign rf_value = reg_valid ? rf_rd_data[reg_idx*RF_DATA_WIDTH +: RF_DATA_WIDTH] : '0;
	assign int_any = |int_vector;

	// Reply words in the same layout as the request
	always_comb
	begin
		rf_reply.rf.reg_addr = rx_word.rf.reg_addr;
		rf_reply.rf.reg_data = rf_value;
		mem_reply.mem.mem_addr = mem_addr;
		mem_reply.mem.reserved = '0;
		mem_reply.mem.mem_data = mem_rd_data;
	end

	// Lowest-numbered line wins
	always_comb
	begin
		int_sel = '0;
		for (int i = INT_DEPTH - 1; i >= 0; i--)
		begin
			if (int_vector[i])
				int_sel = INT_IDX_WIDTH'(i);
		end
	end

	always_ff @(posedge clk or negedge ctrl_rst_n)
	begin
		if (!ctrl_rst_n)
		begin
			state <= LC_IDLE;
			rx_ack <= 1'b0;
			tx_req <= 1'b0;
			clr_int <= '0;
			lc_sleep <= 1'b0;
			rf_load <= '0;
			mem_req <= 1'b0;
		end
		else if (lc_clk_en)
		begin
			// Pulses last a single cycle
			rx_ack <= 1'b0;
			clr_int <= '0;
			lc_sleep <= 1'b0;
			rf_load <= '0;
			mem_req <= 1'b0;
			case (state)
				LC_IDLE:
				begin
					if (rx_req)
					begin
						case (rx_fid)
							FID_REG_WR:
							begin
								if (reg_valid)
									rf_load[reg_idx] <= 1'b1;
								rx_ack <= 1'b1;
								state <= LC_DONE;
							end
							FID_REG_RD:
							begin
								tx_req <= 1'b1;
								state <= LC_REPLY;
							end
							FID_MEM_WR, FID_MEM_RD:
							begin
								mem_req <= 1'b1;
								state <= LC_MEM_WAIT;
							end
							FID_SLEEP:
							begin
								rx_ack <= 1'b1;
								state <= LC_SLEEP;
							end
							// Unknown ids are acknowledged and dropped
							default:
							begin
								rx_ack <= 1'b1;
								state <= LC_DONE;
							end
						endcase
					end
					else if (int_any)
					begin
						tx_req <= 1'b1;
						state <= LC_INT_TX;
					end
				end
				LC_MEM_WAIT:
				begin
					if (mem_ack && mem_write)
					begin
						rx_ack <= 1'b1;
						state <= LC_DONE;
					end
					else if (mem_ack)
					begin
						tx_req <= 1'b1;
						state <= LC_REPLY;
					end
				end
				LC_REPLY:
				begin
					if (tx_ack)
					begin
						tx_req <= 1'b0;
						rx_ack <= 1'b1;
						state <= LC_DONE;
					end
				end
				LC_INT_TX:
				begin
					if (tx_ack)
					begin
						tx_req <= 1'b0;
						clr_int[int_idx] <= 1'b1;
						state <= LC_DONE;
					end
				end
				LC_SLEEP:
				begin
					lc_sleep <= 1'b1;
					state <= LC_HALT;
				end
				// Lets the sender drop its request before the next accept
				LC_DONE: state <= LC_IDLE;
				// Wait here for the power-down reset
				default: state <= LC_HALT;
			endcase
		end
	end

	// Payload captured at accept, and mem read data on mem_ack
	always_ff @(posedge clk)
	begin
		if (lc_clk_en)
		begin
			case (state)
				LC_IDLE:
				begin
					if (rx_req)
					begin
						rf_wr_data <= rx_word.rf.reg_data;
						mem_addr <= rx_word.mem.mem_addr;
						mem_wr_data <= rx_word.mem.mem_data;
						mem_write <= (rx_fid == FID_MEM_WR);
						tx_fid <= FID_REPLY;
						tx_data <= rf_reply;
					end
					else if (int_any)
					begin
						tx_fid <= FID_INT;
						tx_data <= INT_PAYLOAD[int_sel];
						int_idx <= int_sel;
					end
				end
				LC_MEM_WAIT:
				begin
					if (mem_ack)
						tx_data <= mem_reply;
				end
				default: ;
			endcase
		end
	end

	tx_hold: assert property (@(posedge clk) disable iff (!ctrl_rst_n)
		tx_req && !tx_ack |=> tx_req && $stable(tx_data) && $stable(tx_fid))
		else $error("layer_ctrl: transmit word changed before tx_ack");

	rf_load_onehot: assert property (@(posedge clk) disable iff (!ctrl_rst_n) $onehot0(rf_load))
		else $error("layer_ctrl: more than one register strobe");

endmodule

`default_nettype wire

/* verilog/rf_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module rf_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic [lc_pkg::RF_DEPTH-1:0] rf_load,
	input  logic [lc_pkg::RF_DATA_WIDTH-1:0] rf_wr_data,
	output logic [lc_pkg::RF_DEPTH*lc_pkg::RF_DATA_WIDTH-1:0] rf_rd_data
);

	import lc_pkg::*;

	logic [RF_DEPTH-1:0][RF_DATA_WIDTH-1:0] regs;

	// Each register has its own load strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			regs <= '0;
		else
		begin
			for (int i = 0; i < RF_DEPTH; i++)
			begin
				if (rf_load[i])
					regs[i] <= rf_wr_data;
			end
		end
	end

	// Register i sits at bits [i*RF_DATA_WIDTH +: RF_DATA_WIDTH]
	assign rf_rd_data = regs;

	// Checked after the isolation clamp, on the always-on side
	load_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(rf_load))
		else $error("rf_ctrl: several registers loaded at once");

endmodule

`default_nettype wire

/* verilog/mem_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic mem_req,
	input  logic mem_write,
	input  logic [lc_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,
	input  logic [lc_pkg::MEM_DATA_WIDTH-1:0] mem_wr_data,
	output logic mem_ack,
	output logic [lc_pkg::MEM_DATA_WIDTH-1:0] mem_rd_data
);

	import lc_pkg::*;

	logic [MEM_DATA_WIDTH-1:0] mem_array [MEM_DEPTH];

	// Acknowledge one cycle after the request is sampled
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			mem_ack <= 1'b0;
		else
			mem_ack <= mem_req;
	end

	// Read data lands together with mem_ack
	always_ff @(posedge clk)
	begin
		if (mem_req)
		begin
			if (mem_write)
				mem_array[mem_addr] <= mem_wr_data;
			else
				mem_rd_data <= mem_array[mem_addr];
		end
	end

	// Requester must drop its single-cycle request before the acknowledge
	req_not_held: assert property (@(posedge clk) disable iff (!arst_n) mem_ack |-> !mem_req)
		else $error("mem_ctrl: request still high during acknowledge");

endmodule

`default_nettype wire

/* verilog/layer_wrapper.sv */
`timescale 1ns/100ps
`default_nettype none

module layer_wrapper (
	input  logic clk,
	input  logic arst_n,
	input  logic rx_req,
	input  logic [lc_pkg::FID_WIDTH-1:0] rx_fid,
	input  logic [lc_pkg::DATA_WIDTH-1:0] rx_data,
	output logic rx_ack,
	output logic tx_req,
	output logic [lc_pkg::FID_WIDTH-1:0] tx_fid,
	output logic [lc_pkg::DATA_WIDTH-1:0] tx_data,
	input  logic tx_ack,
	input  logic [lc_pkg::INT_DEPTH-1:0] int_vector,
	output logic [lc_pkg::INT_DEPTH-1:0] clr_int,
	output logic lc_power
);

	import lc_pkg::*;

	// Power control of the controller domain
	logic lc_clk_en;
	logic lc_rst_n;
	logic lc_sleep;

	// Controller outputs before the isolation clamp
	logic rx_ack_lc;
	logic tx_req_lc;
	logic [FID_WIDTH-1:0] tx_fid_lc;
	logic [DATA_WIDTH-1:0] tx_data_lc;
	logic [INT_DEPTH-1:0] clr_int_lc;
	logic [RF_DEPTH-1:0] rf_load_lc;
	logic [RF_DATA_WIDTH-1:0] rf_wr_data_lc;
	logic mem_req_lc;
	logic mem_write_lc;
	logic [MEM_ADDR_WIDTH-1:0] mem_addr_lc;
	logic [MEM_DATA_WIDTH-1:0] mem_wr_data_lc;

	// Clamped side, into the always-on storage
	logic [RF_DEPTH-1:0] rf_load;
	logic [RF_DATA_WIDTH-1:0] rf_wr_data;
	logic [RF_DEPTH*RF_DATA_WIDTH-1:0] rf_rd_data;
	logic mem_req;
	logic mem_write;
	logic [MEM_ADDR_WIDTH-1:0] mem_addr;
	logic [MEM_DATA_WIDTH-1:0] mem_wr_data;
	logic mem_ack;
	logic [MEM_DATA_WIDTH-1:0] mem_rd_data;

	power_ctrl pwr0 (
		.clk(clk),
		.arst_n(arst_n),
		.rx_req(rx_req),
		.int_vector(int_vector),
		.lc_sleep(lc_sleep),
		.lc_power(lc_power),
		.lc_clk_en(lc_clk_en),
		.lc_rst_n(lc_rst_n),
		.lc_iso(),
		.rx_ack_lc(rx_ack_lc),
		.tx_req_lc(tx_req_lc),
		.tx_fid_lc(tx_fid_lc),
		.tx_data_lc(tx_data_lc),
		.clr_int_lc(clr_int_lc),
		.rf_load_lc(rf_load_lc),
		.rf_wr_data_lc(rf_wr_data_lc),
		.mem_req_lc(mem_req_lc),
		.mem_write_lc(mem_write_lc),
		.mem_addr_lc(mem_addr_lc),
		.mem_wr_data_lc(mem_wr_data_lc),
		.rx_ack(rx_ack),
		.tx_req(tx_req),
		.tx_fid(tx_fid),
		.tx_data(tx_data),
		.clr_int(clr_int),
		.rf_load(rf_load),
		.rf_wr_data(rf_wr_data),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wr_data(mem_wr_data)
	);

	layer_ctrl lc0 (
		.clk(clk),
		.arst_n(arst_n),
		.lc_clk_en(lc_clk_en),
		.lc_rst_n(lc_rst_n),
		.rx_req(rx_req),
		.rx_fid(rx_fid),
		.rx_data(rx_data),
		.rx_ack(rx_ack_lc),
		.tx_req(tx_req_lc),
		.tx_fid(tx_fid_lc),
		.tx_data(tx_data_lc),
		.tx_ack(tx_ack),
		.int_vector(int_vector),
		.clr_int(clr_int_lc),
		.lc_sleep(lc_sleep),
		.rf_wr_data(rf_wr_data_lc),
		.rf_load(rf_load_lc),
		.rf_rd_data(rf_rd_data),
		.mem_req(mem_req_lc),
		.mem_write(mem_write_lc),
		.mem_addr(mem_addr_lc),
		.mem_wr_data(mem_wr_data_lc),
		.mem_ack(mem_ack),
		.mem_rd_data(mem_rd_data)
	);

	// Always-on storage
	rf_ctrl rf0 (
		.clk(clk),
		.arst_n(arst_n),
		.rf_load(rf_load),
		.rf_wr_data(rf_wr_data),
		.rf_rd_data(rf_rd_data)
	);

	mem_ctrl mem0 (
		.clk(clk),
		.arst_n(arst_n),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wr_data(mem_wr_data),
		.mem_ack(mem_ack),
		.mem_rd_data(mem_rd_data)
	);

endmodule

`default_nettype wire

/* verification/tb_layer_wrapper.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_layer_wrapper;

	import lc_pkg::*;

	localparam int DRIVE_DELAY = 2;
	localparam int POWER_WAIT = 16;
	localparam int CYCLES_PER_LINE = 200;

	logic clk;
	logic arst_n;
	logic rx_req;
	logic [FID_WIDTH-1:0] rx_fid;
	logic [DATA_WIDTH-1:0] rx_data;
	logic rx_ack;
	logic tx_req;
	logic [FID_WIDTH-1:0] tx_fid;
	logic [DATA_WIDTH-1:0] tx_data;
	logic tx_ack;
	logic [INT_DEPTH-1:0] int_vector;
	logic [INT_DEPTH-1:0] clr_int;
	logic lc_power;

	// Steps read from the pattern file
	string op_q[$];
	string name_q[$];
	logic [FID_WIDTH-1:0] fid_q[$];
	logic [DATA_WIDTH-1:0] data_q[$];
	logic [DATA_WIDTH-1:0] exp_q[$];

	int cycle_count = 0;
	int cycle_limit = 0;
	bit rx_pending;
	int step;

	layer_wrapper dut (
		.clk(clk),
		.arst_n(arst_n),
		.rx_req(rx_req),
		.rx_fid(rx_fid),
		.rx_data(rx_data),
		.rx_ack(rx_ack),
		.tx_req(tx_req),
		.tx_fid(tx_fid),
		.tx_data(tx_data),
		.tx_ack(tx_ack),
		.int_vector(int_vector),
		.clr_int(clr_int),
		.lc_power(lc_power)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
			abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
				cycle_limit));
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string test_name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] %s: expected %h, actual %h", test_name, expected,
				actual));
	endtask

	// Samples and drives happen just after the rising edge
	task automatic next_cycle;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic load_patterns;
		int fd;
		int n;
		string line;
		string op;
		string name;
		logic [FID_WIDTH-1:0] fid;
		logic [DATA_WIDTH-1:0] data;
		logic [DATA_WIDTH-1:0] expected;
		fd = $fopen("verification/lc_patterns.txt", "r");
		if (fd == 0)
			abort_run("Could not open the pattern file verification/lc_patterns.txt");
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%s %s %h %h %h", op, name, fid, data, expected);
				if (n != 5)
					abort_run($sformatf("Malformed line in the pattern file: %s", line));
				op_q.push_back(op);
				name_q.push_back(name);
				fid_q.push_back(fid);
				data_q.push_back(data);
				exp_q.push_back(expected);
			end
			$fclose(fd);
		end
	endtask

	// The domain must be awake whenever a request is acknowledged
	task automatic end_request(input string test_name);
		check_value({test_name, "_power"}, 1, lc_power);
		rx_req = 1'b0;
		rx_fid = '0;
		rx_data = '0;
		rx_pending = 1'b0;
		next_cycle();
	endtask

	task automatic send_message(input int idx, input bit reply_follows);
		rx_fid = fid_q[idx];
		rx_data = data_q[idx];
		rx_req = 1'b1;
		if (reply_follows)
			rx_pending = 1'b1;
		else
		begin
			while (!rx_ack)
				next_cycle();
			end_request(name_q[idx]);
		end
	endtask

	task automatic expect_reply(input int idx);
		logic [DATA_WIDTH-1:0] expected;
		logic [DATA_WIDTH-1:0] held_data;
		logic [FID_WIDTH-1:0] held_fid;
		int int_line;
		int i;
		string name;
		name = name_q[idx];
		int_line = 0;
		expected = exp_q[idx];
		if (fid_q[idx] == FID_INT)
		begin
			int_line = exp_q[idx][INT_IDX_WIDTH-1:0];
			expected = INT_PAYLOAD[int_line];
		end
		else if (fid_q[idx] != FID_REPLY)
			abort_run($sformatf("Pattern %s expects an unknown reply function id", name));
		while (!tx_req)
			next_cycle();
		check_value({name, "_fid"}, fid_q[idx], tx_fid);
		check_value({name, "_data"}, expected, tx_data);
		held_data = tx_data;
		held_fid = tx_fid;
		// Withhold tx_ack for the stall count in the data column
		for (i = 0; i < data_q[idx]; i++)
		begin
			next_cycle();
			check_value({name, "_stall_tx_req"}, 1, tx_req);
			check_value({name, "_stall_fid"}, held_fid, tx_fid);
			check_value({name, "_stall_data"}, held_data, tx_data);
			check_value({name, "_stall_rx_ack"}, 0, rx_ack);
		end
		tx_ack = 1'b1;
		next_cycle();
		tx_ack = 1'b0;
		check_value({name, "_tx_req_low"}, 0, tx_req);
		if (fid_q[idx] == FID_INT)
		begin
			while (clr_int == '0)
				next_cycle();
			check_value({name, "_clr_int"}, 1 << int_line, clr_int);
			// Source drops its line after the clear pulse
			int_vector[int_line] = 1'b0;
		end
		else if (rx_pending)
		begin
			while (!rx_ack)
				next_cycle();
			end_request(name);
		end
	endtask

	task automatic raise_interrupts(input int idx);
		int_vector = int_vector | data_q[idx][INT_DEPTH-1:0];
	endtask

	// Power level may take a few cycles to settle after wake or sleep
	task automatic expect_power(input int idx);
		int waited;
		waited = 0;
		while (lc_power !== exp_q[idx][0] && waited < POWER_WAIT)
		begin
			next_cycle();
			waited++;
		end
		check_value(name_q[idx], exp_q[idx], lc_power);
	endtask

	initial
	begin
		arst_n = 1'b0;
		rx_req = 1'b0;
		rx_fid = '0;
		rx_data = '0;
		tx_ack = 1'b0;
		int_vector = '0;
		rx_pending = 1'b0;
		load_patterns();
		cycle_limit = CYCLES_PER_LINE * op_q.size();
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		for (step = 0; step < op_q.size(); step++)
		begin
			if (op_q[step] == "S")
				send_message(step, (step + 1 < op_q.size()) && (op_q[step + 1] == "R"));
			else if (op_q[step] == "R")
				expect_reply(step);
			else if (op_q[step] == "I")
				raise_interrupts(step);
			else if (op_q[step] == "P")
				expect_power(step);
			else
				abort_run($sformatf("Unknown operation %s in pattern %s", op_q[step],
					name_q[step]));
		end
		if (rx_pending)
			abort_run("A request was still waiting for its acknowledge at the end");
		else
		begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
verilog/lc_pkg.sv
verilog/power_ctrl.sv
verilog/layer_ctrl.sv
verilog/rf_ctrl.sv
verilog/mem_ctrl.sv
verilog/layer_wrapper.sv
verification/tb_layer_wrapper.sv

/* verification/lc_patterns.txt */
# op name fid data expected, numbers in hex
# S send (fid, word)  R reply (fid, stall cycles, word or irq line)  I irq mask  P lc_power
P reset_asleep 0 00000000 00000000
S wake_wr_r3 0 03ABCDEF 00000000
P wake_power_on 0 00000000 00000001
S wr_r0 0 00123456 00000000
S wr_r15 0 0F00BEEF 00000000
S wr_r20 0 14777777 00000000
S rd_r3 1 03000000 00000000
R rd_r3_reply e 00000000 03ABCDEF
S rd_r0 1 00000000 00000000
R rd_r0_reply e 00000000 00123456
S rd_r15 1 0F000000 00000000
R rd_r15_reply e 00000000 0F00BEEF
S rd_r20 1 14000000 00000000
R rd_r20_reply e 00000000 14000000
S union_reg_wr 0 05A51234 00000000
S union_mem_wr 2 05A51234 00000000
S mem_wr_80 2 80FF5A5A 00000000
S rd_r5 1 05000000 00000000
R rd_r5_reply e 00000000 05A51234
S rd_m5 3 05000000 00000000
R rd_m5_reply e 00000000 05001234
S rd_m80 3 80000000 00000000
R rd_m80_reply e 00000000 80005A5A
I irq_lines_2_0 0 00000005 00000000
R irq_line0 d 00000000 00000000
R irq_line2 d 00000000 00000002
S sleep_cmd 4 00000000 00000000
P sleep_power_off 0 00000000 00000000
S ret_rd_r3 1 03000000 00000000
R ret_r3_reply e 00000000 03ABCDEF
S ret_rd_m80 3 80000000 00000000
R ret_m80_reply e 00000000 80005A5A
S stall_rd_r15 1 0F000000 00000000
R stall_r15_reply e 0000000A 0F00BEEF
